/* dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    // instruction word and its major opcode field (low bits)
    localparam int inst_width = 32;
    localparam int opcode_width = 7;

    // program-order tag, wraps from 15 back to 0
    localparam int tag_width = 4;

    // issue queue entries carry the tag above the instruction word
    localparam int issue_entry_width = tag_width + inst_width;

    // queue depths
    localparam int inst_queue_depth = 8;
    localparam int issue_queue_depth = 4;

    // RISC-V major opcodes that the dispatch stage knows about
    typedef enum logic [opcode_width-1:0] {
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_alu_imm = 7'b0010011,
        op_alu_reg = 7'b0110011,
        op_lui     = 7'b0110111,
        op_branch  = 7'b1100011,
        op_jal     = 7'b1101111
    } opcode_e;

    // where the head instruction is sent
    // loads and stores go to the memory queue, everything known goes to the alu queue,
    // and anything else is dropped
    typedef enum logic [1:0] {
        route_alu  = 2'd0,
        route_mem  = 2'd1,
        route_drop = 2'd2
    } route_e;

endpackage

`default_nettype wire

/* fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo #(
    parameter int n_entries = 8,
    parameter int entry_width = 32
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic flush,

    // enqueue side
    input wire logic enq_valid,
    input wire logic [entry_width-1:0] enq_data,
    output logic enq_ready,

    // dequeue side
    input wire logic deq_ready,
    output logic deq_valid,
    output logic [entry_width-1:0] deq_data
);

    // index width into the entry array
    localparam int ptr_width = $clog2(n_entries);

    // entry storage
    logic [entry_width-1:0] entries [n_entries];

    // pointer counters carry one extra bit so full and empty can be told apart
    logic [ptr_width:0] enq_ctr;
    logic [ptr_width:0] deq_ctr;

    // slot indices are the low bits of the counters
    logic [ptr_width-1:0] enq_ptr;
    logic [ptr_width-1:0] deq_ptr;

    // status
    logic same_slot;
    logic same_lap;
    logic fifo_empty;
    logic fifo_full;

    // handshake strobes
    logic enq;
    logic deq;

    assign enq_ptr = enq_ctr[ptr_width-1:0];
    assign deq_ptr = deq_ctr[ptr_width-1:0];

    assign same_slot = (enq_ptr == deq_ptr);
    assign same_lap = (enq_ctr[ptr_width] == deq_ctr[ptr_width]);

    // equal counters mean empty
    assign fifo_empty = same_slot && same_lap;
    // same slot but one lap apart means full
    assign fifo_full = same_slot && !same_lap;

    // enq_ready only looks at the full flag, a same-cycle dequeue does not help
    assign enq_ready = !fifo_full;
    assign deq_valid = !fifo_empty;

    // a transfer happens when both sides agree, flush cancels both
    assign enq = enq_valid && enq_ready && !flush;
    assign deq = deq_valid && deq_ready && !flush;

    // head entry read straight out of the array
    assign deq_data = entries[deq_ptr];

    // enqueue pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enq_ctr <= '0;
        end else if (flush) begin
            enq_ctr <= '0;
        end else if (enq) begin
            enq_ctr <= enq_ctr + 1'b1;
        end
    end

    // dequeue pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            deq_ctr <= '0;
        end else if (flush) begin
            deq_ctr <= '0;
        end else if (deq) begin
            deq_ctr <= deq_ctr + 1'b1;
        end
    end

    // write the incoming entry into the slot at the enqueue pointer
    always_ff @(posedge clk) begin
        if (enq) begin
            entries[enq_ptr] <= enq_data;
        end
    end

endmodule

`default_nettype wire

/* dispatch_router.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_router (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic flush,

    // head of the instruction queue
    input wire logic head_valid,
    input wire logic [dispatch_pkg::inst_width-1:0] head_inst,
    output logic head_ready,

    // alu issue queue enqueue side
    output logic alu_enq_valid,
    output logic [dispatch_pkg::issue_entry_width-1:0] alu_enq_data,
    input wire logic alu_enq_ready,

    // memory issue queue enqueue side
    output logic mem_enq_valid,
    output logic [dispatch_pkg::issue_entry_width-1:0] mem_enq_data,
    input wire logic mem_enq_ready,

    // one-cycle pulse after an unknown opcode is dropped
    output logic illegal_inst
);

    import dispatch_pkg::*;

    opcode_e opcode;
    route_e route;

    // program-order tag for the next legal instruction
    logic [tag_width-1:0] tag;

    // tagged entry, the same word goes to whichever queue is chosen
    logic [issue_entry_width-1:0] tagged_inst;

    logic target_ready;
    logic legal_move;
    logic drop_move;
    logic illegal_q;

    assign opcode = opcode_e'(head_inst[opcode_width-1:0]);

    // classify the head by its major opcode
    always_comb begin
        case (opcode)
            op_load, op_store: begin
                route = route_mem;
            end
            op_alu_imm, op_alu_reg, op_lui, op_branch, op_jal: begin
                route = route_alu;
            end
            default: begin
                route = route_drop;
            end
        endcase
    end

    assign tagged_inst = {tag, head_inst};

    // valid goes only toward the chosen queue, nothing moves during flush
    assign alu_enq_valid = head_valid && (route == route_alu) && !flush;
    assign mem_enq_valid = head_valid && (route == route_mem) && !flush;
    assign alu_enq_data = tagged_inst;
    assign mem_enq_data = tagged_inst;

    always_comb begin
        case (route)
            route_alu: target_ready = alu_enq_ready;
            route_mem: target_ready = mem_enq_ready;
            default: target_ready = 1'b1;
        endcase
    end

    // an illegal head needs no target and is always taken
    assign head_ready = target_ready && !flush;

    assign legal_move = (alu_enq_valid && alu_enq_ready) || (mem_enq_valid && mem_enq_ready);
    assign drop_move = head_valid && head_ready && (route == route_drop);

    // tag advances only for instructions that reach an issue queue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag <= '0;
        end else if (flush) begin
            tag <= '0;
        end else if (legal_move) begin
            tag <= tag + 1'b1;
        end
    end

    // drop report, high for the cycle after the edge that consumed the head
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            illegal_q <= 1'b0;
        end else begin
            illegal_q <= drop_move;
        end
    end

    assign illegal_inst = illegal_q;

endmodule

`default_nettype wire

/* dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic flush,

    // fetched instructions
    input wire logic inst_valid,
    input wire logic [dispatch_pkg::inst_width-1:0] inst,
    output logic inst_ready,

    // alu issue port
    output logic alu_valid,
    input wire logic alu_ready,
    output logic [dispatch_pkg::tag_width-1:0] alu_tag,
    output logic [dispatch_pkg::inst_width-1:0] alu_inst,

    // memory issue port
    output logic mem_valid,
    input wire logic mem_ready,
    output logic [dispatch_pkg::tag_width-1:0] mem_tag,
    output logic [dispatch_pkg::inst_width-1:0] mem_inst,

    output logic illegal_inst
);

    import dispatch_pkg::*;

    // instruction queue head
    logic head_valid;
    logic head_ready;
    logic [inst_width-1:0] head_inst;

    // router to issue queues
    logic alu_enq_valid;
    logic alu_enq_ready;
    logic [issue_entry_width-1:0] alu_enq_data;
    logic mem_enq_valid;
    logic mem_enq_ready;
    logic [issue_entry_width-1:0] mem_enq_data;

    // issue queue heads before the tag split
    logic [issue_entry_width-1:0] alu_deq_data;
    logic [issue_entry_width-1:0] mem_deq_data;

    fifo #(
        .n_entries(inst_queue_depth),
        .entry_width(inst_width)
    ) inst_queue (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .enq_valid(inst_valid),
        .enq_data(inst),
        .enq_ready(inst_ready),
        .deq_ready(head_ready),
        .deq_valid(head_valid),
        .deq_data(head_inst)
    );

    dispatch_router router_i (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .head_valid(head_valid),
        .head_inst(head_inst),
        .head_ready(head_ready),
        .alu_enq_valid(alu_enq_valid),
        .alu_enq_data(alu_enq_data),
        .alu_enq_ready(alu_enq_ready),
        .mem_enq_valid(mem_enq_valid),
        .mem_enq_data(mem_enq_data),
        .mem_enq_ready(mem_enq_ready),
        .illegal_inst(illegal_inst)
    );

    fifo #(
        .n_entries(issue_queue_depth),
        .entry_width(issue_entry_width)
    ) alu_queue (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .enq_valid(alu_enq_valid),
        .enq_data(alu_enq_data),
        .enq_ready(alu_enq_ready),
        .deq_ready(alu_ready),
        .deq_valid(alu_valid),
        .deq_data(alu_deq_data)
    );

    fifo #(
        .n_entries(issue_queue_depth),
        .entry_width(issue_entry_width)
    ) mem_queue (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .enq_valid(mem_enq_valid),
        .enq_data(mem_enq_data),
        .enq_ready(mem_enq_ready),
        .deq_ready(mem_ready),
        .deq_valid(mem_valid),
        .deq_data(mem_deq_data)
    );

    // tag sits above the instruction word
    assign alu_tag = alu_deq_data[issue_entry_width-1:inst_width];
    assign alu_inst = alu_deq_data[inst_width-1:0];
    assign mem_tag = mem_deq_data[issue_entry_width-1:inst_width];
    assign mem_inst = mem_deq_data[inst_width-1:0];

endmodule

`default_nettype wire

/* tb_dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch_unit;

    import dispatch_pkg::*;

    logic clk = 1'b0;
    logic rst_n;
    logic flush;
    logic inst_valid;
    logic [inst_width-1:0] inst;
    logic inst_ready;
    logic alu_valid;
    logic alu_ready;
    logic [tag_width-1:0] alu_tag;
    logic [inst_width-1:0] alu_inst;
    logic mem_valid;
    logic mem_ready;
    logic [tag_width-1:0] mem_tag;
    logic [inst_width-1:0] mem_inst;
    logic illegal_inst;

    // commands from the data file, one entry per command line
    logic [7:0] cmd_q[$];
    logic [inst_width-1:0] arg_q[$];
    logic [7:0] route_q[$];

    // scoreboards, {tag, instruction} in the order the DUT should issue them
    logic [issue_entry_width-1:0] alu_q[$];
    logic [issue_entry_width-1:0] mem_q[$];
    logic [inst_width-1:0] drop_q[$];

    logic [tag_width-1:0] model_tag = '0;
    logic [7:0] offered_route = "D";
    logic ready_mode = 1'b0;
    logic used_random = 1'b0;
    logic saw_stall = 1'b0;
    logic after_flush = 1'b0;
    integer seed;
    int errors = 0;
    int checks = 0;
    int line_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    dispatch_unit dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .inst_valid(inst_valid),
        .inst(inst),
        .inst_ready(inst_ready),
        .alu_valid(alu_valid),
        .alu_ready(alu_ready),
        .alu_tag(alu_tag),
        .alu_inst(alu_inst),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem_tag(mem_tag),
        .mem_inst(mem_inst),
        .illegal_inst(illegal_inst)
    );

    always #50 clk = ~clk;

    task automatic check_value(input logic [issue_entry_width-1:0] actual,
                               input logic [issue_entry_width-1:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic load_tests();
        int fd;
        int code;
        int want;
        int ch;
        logic [7:0] c;
        logic [7:0] rt;
        logic [inst_width-1:0] word;
        logic done;
        fd = $fopen("dispatch_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dispatch_tests.txt for reading");
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", c);
                if (code != 1) begin
                    done = 1'b1;
                end else if (c == "#") begin
                    line_count++;
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    line_count++;
                    word = '0;
                    rt = "D";
                    want = 0;
                    code = 0;
                    if (c == "I") begin
                        want = 2;
                        code = $fscanf(fd, "%h %c", word, rt);
                    end else if (c == "W" || c == "P") begin
                        want = 1;
                        code = $fscanf(fd, "%d", word);
                    end
                    if (code != want || !(c inside {"I", "W", "P", "F"}) ||
                        !(rt inside {"A", "M", "D"})) begin
                        errors++;
                        $display("line %0d of dispatch_tests.txt could not be parsed", line_count);
                    end else begin
                        cmd_q.push_back(c);
                        arg_q.push_back(word);
                        route_q.push_back(rt);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // expected result of an instruction the DUT has just taken
    task automatic book_inst(input logic [inst_width-1:0] word, input logic [7:0] route);
        if (route == "A") begin
            alu_q.push_back({model_tag, word});
            model_tag = model_tag + 1'b1;
        end else if (route == "M") begin
            mem_q.push_back({model_tag, word});
            model_tag = model_tag + 1'b1;
        end else begin
            drop_q.push_back(word);
        end
    endtask

    // one clock cycle, entered and left at a falling edge
    task automatic advance();
        logic [31:0] rnd;
        if (ready_mode) begin
            // each port ready about a quarter of the time so the queues fill up
            rnd = $random(seed);
            alu_ready = rnd[0] & rnd[1];
            mem_ready = rnd[2] & rnd[3];
        end else begin
            alu_ready = 1'b1;
            mem_ready = 1'b1;
        end
        if (after_flush) begin
            check_value(issue_entry_width'(alu_valid), '0, "alu_valid after flush");
            check_value(issue_entry_width'(mem_valid), '0, "mem_valid after flush");
            check_value(issue_entry_width'(illegal_inst), '0, "illegal_inst after flush");
        end
        // a pulse seen now belongs to a drop at the last rising edge
        if (illegal_inst) begin
            if (drop_q.size() == 0) begin
                errors++;
                $display("illegal_inst pulsed at %0t with no dropped instruction pending", $time);
            end else begin
                void'(drop_q.pop_front());
            end
        end
        after_flush = flush;
        if (flush) begin
            alu_q.delete();
            mem_q.delete();
            drop_q.delete();
            model_tag = '0;
        end else begin
            if (inst_valid && inst_ready) begin
                book_inst(inst, offered_route);
            end
            if (alu_valid && alu_ready) begin
                if (alu_q.size() == 0) begin
                    errors++;
                    $display("alu port issued %h at %0t but nothing was expected", alu_inst, $time);
                end else begin
                    check_value({alu_tag, alu_inst}, alu_q.pop_front(), "alu tag and instruction");
                end
            end
            if (mem_valid && mem_ready) begin
                if (mem_q.size() == 0) begin
                    errors++;
                    $display("mem port issued %h at %0t but nothing was expected", mem_inst, $time);
                end else begin
                    check_value({mem_tag, mem_inst}, mem_q.pop_front(), "mem tag and instruction");
                end
            end
        end
        if (ready_mode && !inst_ready) begin
            saw_stall = 1'b1;
        end
        @(negedge clk);
    endtask

    task automatic send_inst(input logic [inst_width-1:0] word, input logic [7:0] route);
        // offered only while the instruction queue has room
        while (!inst_ready) begin
            advance();
        end
        inst = word;
        inst_valid = 1'b1;
        offered_route = route;
        advance();
        inst_valid = 1'b0;
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        advance();
        flush = 1'b0;
    endtask

    task automatic drain_outputs();
        ready_mode = 1'b0;
        while (alu_q.size() != 0 || mem_q.size() != 0 || drop_q.size() != 0) begin
            advance();
        end
        // idle on so that a duplicated entry would still show up
        repeat (12) advance();
    endtask

    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [inst_width-1:0] arg;
        rst_n = 1'b0;
        flush = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        alu_ready = 1'b1;
        mem_ready = 1'b1;
        seed = 32'ha3a9;
        load_tests();
        cycle_limit = line_count * 40 + 1000;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_value(issue_entry_width'(inst_ready), issue_entry_width'(1'b1), "inst_ready after reset");
        check_value(issue_entry_width'(alu_valid), '0, "alu_valid after reset");
        check_value(issue_entry_width'(mem_valid), '0, "mem_valid after reset");
        check_value(issue_entry_width'(illegal_inst), '0, "illegal_inst after reset");
        for (int i = 0; i < cmd_q.size(); i++) begin
            arg = arg_q[i];
            case (cmd_q[i])
                "I": send_inst(arg, route_q[i]);
                "F": apply_flush();
                "W": repeat (arg) advance();
                default: begin
                    ready_mode = arg[0];
                    used_random = used_random | arg[0];
                end
            endcase
        end
        drain_outputs();
        if (used_random) begin
            check_value(issue_entry_width'(saw_stall), issue_entry_width'(1'b1),
                        "inst_ready seen low under back-pressure");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dispatch_tests.txt */
# one command per line: I <instruction hex> <route A|M|D>, F flush,
# W <idle cycles>, P <0 always ready | 1 random ready>
# routing with both issue ports always ready
P 0
I 00500093 A
I 002081b3 A
I 0000a303 M
I 0060a223 M
I 123452b7 A
I 00208463 A
I 010000ef A
W 6
# unknown opcodes dropped between legal ones
I 00001117 D
I 00100113 A
I 0000100f D
I 00000073 D
I 0040a383 M
I 0000007f D
I 00000000 D
I 003100b3 A
W 6
# past sixteen legal instructions so the tag wraps
I 00a00513 A
I 00b00593 A
I 0080a403 M
I 00c00613 A
I 0087a023 M
I 40b50533 A
I 00d00693 A
I fe000ee3 A
I 0000aa37 A
I 0100056f A
I 00e00713 A
I 00c12483 M
I 00912623 M
W 8
# random ready, a long alu run fills both queue levels
P 1
I 00100093 A
I 00200113 A
I 00300193 A
I 00400213 A
I 00500293 A
I 00600313 A
I 00700393 A
I 00800413 A
I 00900493 A
I 00a00513 A
I 00b00593 A
I 00c00613 A
I 0000a083 M
I 00002017 D
I 00d00693 A
I 00e00713 A
I 00f00793 A
I 01000813 A
I 01100893 A
I 01200913 A
I 0010a223 M
I 0020a423 M
I 002081b3 A
I 0000006b D
I 01300993 A
I 01400a13 A
W 20
# flush with work still queued, next legal one restarts at tag 0
I 00108093 A
I 0000a503 M
I 00210113 A
I 00c0a023 M
F
I 00318193 A
I 0040a583 M
W 10
# flush catches a drop before it is routed
P 0
I 00000013 A
I 00001117 D
F
I 0020a023 M
I 00420213 A
W 8

/* build.f */
dispatch_pkg.sv
fifo.sv
dispatch_router.sv
dispatch_unit.sv
tb_dispatch_unit.sv

/* run_sim.sh */
#!/bin/sh
# compile the dispatch unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module tb_dispatch_unit -o tb_dispatch_unit \
    && ./obj_dir/tb_dispatch_unit > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
